// File: src.f
hw/mem_pkg.sv
hw/la_spram.sv
hw/mem_bank_array.sv
hw/mem_init_sequencer.sv
hw/mem_subsys_top.sv
bench/mem_subsys_asserts.sv
bench/mem_subsys_tb.sv

// File: run.sh
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -Wno-fatal \
    -f src.f \
    --top-module mem_subsys_tb \
    -o mem_subsys_sim \
    > build.log 2>&1 \
    && ./obj_dir/mem_subsys_sim +verilator+error+limit+1000 > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "ALL TESTS PASSED" sim.log \
    && echo "simulation passed" \
    && exit 0 \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: bench/mem_subsys_tb.sv
`timescale 1ns/1ps

module mem_subsys_tb;

    logic              clk;
    logic              rst_n;
    mem_pkg::mem_req_t host_req;
    mem_pkg::mem_rsp_t host_rsp;
    logic              busy;

    int n_pass;
    int n_fail;
    int fails_at_start;  // checker count when the current test began
    bit aborted;         // set on a busy timeout

    logic [mem_pkg::addr_w-1:0] test_addrs [8];  // shared by the write and read tests
    logic [mem_pkg::addr_w-1:0] bank_addrs [4];  // same row, one per bank
    logic [mem_pkg::addr_w-1:0] drop_addr;       // target of the writes sent while busy
    logic [mem_pkg::data_w-1:0] rand_mask;
    logic [mem_pkg::row_w-1:0]  shared_row;

    mem_subsys_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .busy     (busy)
    );

    bind mem_subsys_top mem_subsys_asserts u_asserts (.*);

    always #4 clk = ~clk;  // 8 ns period

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (3) next_cycle();
        rst_n = 1'b1;
    endtask

    function automatic logic [mem_pkg::addr_w-1:0] rand_addr();
        return mem_pkg::addr_w'($urandom_range(0, mem_pkg::num_banks * mem_pkg::num_rows - 1));
    endfunction

    // one-cycle strobe, then idle
    task automatic drive_req(input logic we, input logic [mem_pkg::addr_w-1:0] addr,
                             input logic [mem_pkg::data_w-1:0] din,
                             input logic [mem_pkg::data_w-1:0] wmask);
        host_req       = '0;
        host_req.en    = 1'b1;
        host_req.we    = we;
        host_req.addr  = addr;
        host_req.din   = din;
        host_req.wmask = wmask;
        next_cycle();
        host_req = '0;
    endtask

    task automatic write_word(input logic [mem_pkg::addr_w-1:0] addr,
                              input logic [mem_pkg::data_w-1:0] din,
                              input logic [mem_pkg::data_w-1:0] wmask);
        drive_req(1'b1, addr, din, wmask);
    endtask

    task automatic read_word(input logic [mem_pkg::addr_w-1:0] addr);
        drive_req(1'b0, addr, '0, '0);
    endtask

    task automatic wait_ready(input string name);
        int cycles;
        cycles = 0;
        while (busy && cycles < 400) begin
            next_cycle();
            cycles++;
        end
        if (busy) begin
            $display("Test %s failed: busy still high after 400 cycles", name);
            n_fail++;
            aborted = 1'b1;
        end
    endtask

    task automatic begin_test();
        fails_at_start = DUT.u_asserts.fail_cnt;
    endtask

    // drain the last response, then compare checker counts
    task automatic end_test(input string name);
        int new_fails;
        repeat (2) next_cycle();
        new_fails = DUT.u_asserts.fail_cnt - fails_at_start;
        if (new_fails == 0) begin
            n_pass++;
            $display("PASS %s", name);
        end else begin
            n_fail++;
            $display("Error: test %s: expected 0 assertion failures, actual %0d",
                     name, new_fails);
        end
    endtask

    initial begin
        void'($urandom(32'h8cb7_1993));
        clk      = 1'b0;
        rst_n    = 1'b1;
        host_req = '0;
        n_pass   = 0;
        n_fail   = 0;
        aborted  = 1'b0;
        #1;  // first reset falls between clock edges

        // 1: sweep length and zeroed contents
        begin_test();
        apply_reset();
        wait_ready("clear_after_reset");
        if (!aborted) begin
            repeat (16) read_word(rand_addr());
            end_test("clear_after_reset");
        end

        if (!aborted) begin
            // 2: full mask write then read back
            begin_test();
            for (int i = 0; i < 8; i++) begin
                test_addrs[i] = rand_addr();
                write_word(test_addrs[i], $urandom(), '1);
            end
            for (int i = 0; i < 8; i++) read_word(test_addrs[i]);
            end_test("full_mask_write");

            // 3: partial mask over known data
            begin_test();
            for (int i = 0; i < 6; i++) begin
                rand_mask = $urandom();
                write_word(test_addrs[i], $urandom(), '1);
                write_word(test_addrs[i], $urandom(), rand_mask);
                read_word(test_addrs[i]);
            end
            end_test("masked_merge");

            // 4: same row in every bank
            begin_test();
            shared_row = mem_pkg::row_w'($urandom_range(0, mem_pkg::num_rows - 1));
            for (int b = 0; b < 4; b++) begin
                bank_addrs[b] = {mem_pkg::bank_bits'(b), shared_row};
                write_word(bank_addrs[b], 32'h1111_1111 * (b + 1), '1);  // distinct per bank
            end
            for (int b = 3; b >= 0; b--) read_word(bank_addrs[b]);
            end_test("bank_independence");

            // 5: en held high across consecutive reads
            begin_test();
            for (int i = 0; i < 8; i++) begin
                host_req      = '0;
                host_req.en   = 1'b1;
                host_req.addr = test_addrs[7 - i];
                next_cycle();
            end
            host_req = '0;
            end_test("back_to_back_reads");

            // 6: traffic during a fresh sweep is discarded
            begin_test();
            drop_addr = {mem_pkg::bank_bits'(2), mem_pkg::row_w'(1)};  // row swept early
            apply_reset();
            repeat (5) next_cycle();
            write_word(drop_addr, 32'hcafe_f00d, '1);  // lands after row 1 is cleared
            read_word(drop_addr);
            repeat (3) next_cycle();
            wait_ready("drop_while_busy");
            if (!aborted) begin
                read_word(drop_addr);      // dropped write left no trace
                read_word(bank_addrs[2]);  // cleared by the sweep
                end_test("drop_while_busy");
            end
        end

        $display("Counts: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0 && !aborted) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: bench/mem_subsys_asserts.sv
`timescale 1ns/1ps

module mem_subsys_asserts (
    input logic              clk,
    input logic              rst_n,
    input mem_pkg::mem_req_t host_req,
    input mem_pkg::mem_rsp_t host_rsp,
    input logic              busy
);

    int fail_cnt = 0;  // read by the testbench around each test

    // shadow of the whole host address space
    logic [mem_pkg::data_w-1:0] shadow [mem_pkg::num_banks * mem_pkg::num_rows];
    logic [mem_pkg::data_w-1:0] exp_word;   // word owed to the pending read
    logic                       rd_acc;     // read taken this cycle
    logic                       wr_acc;     // write taken this cycle
    logic                       rd_acc_q;   // read taken last cycle
    int                         sweep_cnt;  // edges since reset release, saturating

    assign rd_acc = host_req.en && !host_req.we && !busy;
    assign wr_acc = host_req.en && host_req.we && !busy;

    // shadow sits at zero while the sweep runs, so it is clear once busy falls
    always_ff @(posedge clk) begin
        if (busy) begin
            for (int i = 0; i < mem_pkg::num_banks * mem_pkg::num_rows; i++) begin
                shadow[i] <= '0;
            end
        end else if (wr_acc) begin
            for (int b = 0; b < mem_pkg::data_w; b++) begin
                if (host_req.wmask[b]) begin
                    shadow[host_req.addr][b] <= host_req.din[b];  // masked bits only
                end
            end
        end
        if (rd_acc) begin
            exp_word <= shadow[host_req.addr];  // value before any write lands
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_acc_q  <= 1'b0;
            sweep_cnt <= 0;
        end else begin
            rd_acc_q <= rd_acc;
            if (sweep_cnt < mem_pkg::num_rows) begin
                sweep_cnt <= sweep_cnt + 1;
            end
        end
    end

    a_valid_after_read : assert property (@(posedge clk) disable iff (!rst_n)
        rd_acc |=> host_rsp.valid)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("accepted read got no valid one cycle later");
        end

    a_read_data : assert property (@(posedge clk) disable iff (!rst_n)
        host_rsp.valid |-> (host_rsp.data == exp_word))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("read data %h, expected %h", host_rsp.data, exp_word);
        end

    a_no_stray_valid : assert property (@(posedge clk) disable iff (!rst_n)
        host_rsp.valid |-> rd_acc_q)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("valid raised without an accepted read");
        end

    // high in reset and for the full row sweep, low from then on
    a_busy_window : assert property (@(posedge clk)
        busy == (!rst_n || (sweep_cnt < mem_pkg::num_rows)))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("busy is %b after %0d sweep cycles", busy, sweep_cnt);
        end

endmodule

// File: hw/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::mem_req_t host_req,  // no ready, drop while busy
    output mem_pkg::mem_rsp_t host_rsp,  // read data one cycle later
    output logic              busy       // init sweep running
);

    // sequencer output, sole driver of the array
    mem_pkg::mem_req_t array_req;

    // clears all rows after reset then forwards host requests
    mem_init_sequencer u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .host_req  (host_req),
        .array_req (array_req),
        .busy      (busy)
    );

    // four banks plus read return
    mem_bank_array u_array (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (array_req),
        .rsp   (host_rsp)
    );

endmodule

// File: hw/mem_init_sequencer.sv
`timescale 1ns/1ps

module mem_init_sequencer (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::mem_req_t host_req,   // raw host strobes
    output mem_pkg::mem_req_t array_req,  // sweep writes or host traffic
    output logic              busy        // high until every row is cleared
);

    logic [mem_pkg::row_w-1:0] row_cnt;   // row being cleared this cycle
    logic                      busy_q;
    logic                      last_row;  // final row of the sweep

    assign last_row = (row_cnt == mem_pkg::row_w'(mem_pkg::num_rows - 1));

    // sweep state
    // reset parks at row 0 with busy set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_cnt <= '0;
            busy_q  <= 1'b1;
        end else if (busy_q) begin
            row_cnt <= row_cnt + 1'b1;  // wraps to 0 after the last row
            if (last_row) begin
                busy_q <= 1'b0;         // done, stays low until next reset
            end
        end
    end

    assign busy = busy_q;

    // broadcast zero write for the current row
    mem_pkg::mem_req_t sweep_req;

    always_comb begin
        sweep_req           = '0;
        sweep_req.en        = 1'b1;
        sweep_req.we        = 1'b1;
        sweep_req.all_banks = 1'b1;   // every bank at once
        sweep_req.wmask     = '1;     // full word
        sweep_req.addr      = {{mem_pkg::bank_bits{1'b0}}, row_cnt};
        sweep_req.din       = '0;
    end

    // host request as forwarded after the sweep
    mem_pkg::mem_req_t fwd_req;

    always_comb begin
        fwd_req           = host_req;
        fwd_req.all_banks = 1'b0;  // broadcast is not a host feature
    end

    // only gate on host traffic
    // host strobes during busy simply vanish
    always_comb begin
        if (busy_q) begin
            array_req = sweep_req;
        end else begin
            array_req = fwd_req;
        end
    end

endmodule

// File: hw/mem_bank_array.sv
`timescale 1ns/1ps

module mem_bank_array (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::mem_req_t req,  // from the sequencer
    output mem_pkg::mem_rsp_t rsp   // read return, one cycle after the request
);

    // address split
    logic [mem_pkg::bank_bits-1:0] req_bank;  // upper address bits
    logic [mem_pkg::row_w-1:0]     req_row;   // lower address bits

    assign req_bank = req.addr[mem_pkg::addr_w-1 -: mem_pkg::bank_bits];
    assign req_row  = req.addr[mem_pkg::row_w-1:0];

    // per bank chip enables
    logic [mem_pkg::num_banks-1:0] bank_ce;

    // read outputs of every bank
    logic [mem_pkg::data_w-1:0] bank_dout [mem_pkg::num_banks];

    // a read is any strobe without we
    logic rd_fire;

    assign rd_fire = req.en && !req.we;

    // bank decode and ram instances
    for (genvar g = 0; g < mem_pkg::num_banks; g++) begin : g_bank

        // own bank hit, or every bank for a broadcast
        assign bank_ce[g] = req.en &&
                            (req.all_banks || (req_bank == mem_pkg::bank_bits'(g)));

        la_spram #(
            .dw (mem_pkg::data_w),
            .aw (mem_pkg::row_w)
        ) u_ram (
            .clk   (clk),
            .ce    (bank_ce[g]),
            .we    (req.we),     // shared across banks, ce picks the target
            .wmask (req.wmask),
            .addr  (req_row),    // row only, bank bits already decoded
            .din   (req.din),
            .dout  (bank_dout[g])
        );

    end

    // read tracking
    logic                          rd_pending;  // read issued last cycle
    logic [mem_pkg::bank_bits-1:0] rd_bank;     // bank that read went to

    // strobe register, cleared by reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= rd_fire;  // one pulse per read
        end
    end

    // bank number only matters when rd_pending is set
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rd_bank <= req_bank;
        end
    end

    // return path
    logic [mem_pkg::data_w-1:0] rd_data;

    // pick the recorded bank, dout is already registered in the ram
    always_comb begin
        rd_data = bank_dout[0];
        for (int b = 0; b < mem_pkg::num_banks; b++) begin
            if (rd_bank == mem_pkg::bank_bits'(b)) begin
                rd_data = bank_dout[b];
            end
        end
    end

    always_comb begin
        rsp.valid = rd_pending;  // low during reset via the register
        rsp.data  = rd_data;
    end

endmodule

// File: hw/la_spram.sv
`timescale 1ns/1ps

module la_spram #(
    parameter int dw = 32,  // word width
    parameter int aw = 10   // row address width
) (
    input  logic          clk,
    input  logic          ce,     // chip enable
    input  logic          we,     // write when set
    input  logic [dw-1:0] wmask,  // per bit write mask
    input  logic [aw-1:0] addr,
    input  logic [dw-1:0] din,
    output logic [dw-1:0] dout    // registered read word
);

    // storage array, 2**aw words
    logic [dw-1:0] ram [0:(2**aw)-1];

    logic [dw-1:0] cur_word;     // word currently at addr
    logic [dw-1:0] merged_word;  // masked merge of din into cur_word

    assign cur_word = ram[addr];

    // new bits where mask is set, old bits elsewhere
    assign merged_word = (din & wmask) | (cur_word & ~wmask);

    // write port
    always_ff @(posedge clk) begin
        if (ce && we) begin
            ram[addr] <= merged_word;  // whole word stored, mask already applied
        end
    end

    // read port
    // samples before the write lands so a write cycle returns the old word
    always_ff @(posedge clk) begin
        if (ce) begin
            dout <= cur_word;
        end
    end

endmodule

// File: hw/mem_pkg.sv
package mem_pkg;

    // word and address geometry
    localparam int data_w    = 32;              // bits per memory word
    localparam int bank_bits = 2;               // upper address bits pick the bank
    localparam int num_banks = 1 << bank_bits;  // four banks side by side
    localparam int row_w     = 8;               // row address inside one bank
    localparam int num_rows  = 1 << row_w;      // rows per bank and sweep length
    localparam int addr_w    = bank_bits + row_w;

    // one request toward the scratchpad
    // addr holds bank in the upper bits and row in the lower bits
    typedef struct packed {
        logic              en;         // single cycle strobe
        logic              we;         // write when set, read when clear
        logic              all_banks;  // broadcast write, sequencer only
        logic [data_w-1:0] wmask;      // set bit takes the new data bit
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] din;
    } mem_req_t;

    // read return toward the host
    typedef struct packed {
        logic              valid;  // one cycle pulse
        logic [data_w-1:0] data;
    } mem_rsp_t;

endpackage
